// File: vga_stream_consts.svh
// VGA timing, flash command and queue depth constants, included by the RTL and the testbench
`ifndef VGA_STREAM_CONSTS_SVH
`define VGA_STREAM_CONSTS_SVH

// Horizontal timing in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define QSPI_READ_CMD 8'h6B     // Fast read, quad output
`define QUEUE_DEPTH 4           // Instruction queue entries
`define NIBBLES_PER_INSTR 5     // Nibbles fetched per instruction

`endif

// File: vga_stream_pkg.sv
// Shared types for the flash-to-VGA stream, imported by every RTL module of the design
package vga_stream_pkg;

    typedef logic [7:0]  colour_t;      // R3 G3 B2
    typedef logic [9:0]  run_t;         // Run length minus one
    typedef logic [23:0] flash_addr_t;  // Flash byte address
    typedef logic [3:0]  dummy_t;       // Dummy clocks after the address
    typedef logic [1:0]  cfg_sel_t;     // Host register select

    localparam cfg_sel_t sel_ctrl = 2'd0;  // Enable in bit 0, dummy count in 7:4
    localparam cfg_sel_t sel_addr = 2'd1;  // Image start address

    typedef struct packed {
        colour_t colour;
        run_t    run;
    } instr_t;

    typedef struct packed {
        logic        enable;
        flash_addr_t start_addr;
        dummy_t      dummy_cycles;
    } stream_cfg_t;

    typedef enum logic [2:0] {
        qspi_idle, qspi_command, qspi_address, qspi_dummy, qspi_data, qspi_stall
    } qspi_state_t;

    typedef enum logic {
        ack_idle, ack_busy
    } ack_state_t;

endpackage

// File: display_regs.sv
// Stream configuration registers, written by the host over a four-phase req/ack handshake
`timescale 1ns/1ps

module display_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cfg_req,
    input  vga_stream_pkg::cfg_sel_t    cfg_sel,
    input  logic [23:0]                 cfg_wdata,
    output logic                        cfg_ack,
    output vga_stream_pkg::stream_cfg_t cfg
);
    import vga_stream_pkg::*;

    ack_state_t ack_state;

    assign cfg_ack = (ack_state == ack_busy);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_state <= ack_idle;
            cfg       <= '0;                          // Display disabled
        end else begin
            case (ack_state)
                ack_idle: begin
                    if (cfg_req) begin
                        ack_state <= ack_busy;          // Ack on the next clock
                        if (cfg_sel == sel_ctrl) begin
                            cfg.enable       <= cfg_wdata[0];
                            cfg.dummy_cycles <= cfg_wdata[7:4];
                        end else if (cfg_sel == sel_addr) begin
                            cfg.start_addr   <= cfg_wdata;
                        end
                    end
                end
                ack_busy: begin
                    if (!cfg_req) begin
                        ack_state <= ack_idle;          // Host finished the cycle
                    end
                end
                default: ack_state <= ack_idle;
            endcase
        end
    end

    // Host keeps req, select and data steady until the ack comes back
    req_held: assert property (@(posedge clk) disable iff (reset)
        cfg_req && !cfg_ack |=> cfg_req && $stable(cfg_sel) && $stable(cfg_wdata));

endmodule

// File: qspi_reader.sv
// Quad-output fast read sequencer that streams 18-bit draw instructions into the queue
`timescale 1ns/1ps
`include "vga_stream_consts.svh"

module qspi_reader (
    input  logic                        clk,
    input  logic                        reset,
    input  vga_stream_pkg::stream_cfg_t cfg,
    input  logic                        frame_start,
    input  logic                        full,
    output logic                        push,
    output vga_stream_pkg::instr_t      instr,
    output logic                        sclk,
    output logic                        cs_n,
    output logic [3:0]                  io_out,
    output logic [3:0]                  io_oe,
    input  logic [3:0]                  io_in
);
    import vga_stream_pkg::*;

    qspi_state_t state;
    logic        run_en;                          // Enable seen at frame start
    dummy_t      dummy_clks;
    logic [31:0] cmd_sr;                          // Command then address, msb first
    logic [4:0]  bit_cnt;
    logic [2:0]  nib_cnt;
    logic [4*`NIBBLES_PER_INSTR-1:0] nib_sr;
    logic        have_instr;                      // Complete word waiting for the queue
    logic        fall;
    logic        last_bit;

    assign fall   = sclk;                         // This edge takes SCLK low
    assign push   = have_instr && !full;
    assign instr  = nib_sr[17:0];                 // Top two bits of first nibble dropped
    assign io_out = {3'b000, cmd_sr[31]};
    assign io_oe  = (state == qspi_command || state == qspi_address) ? 4'b0001 : 4'b0000;

    always_comb begin
        case (state)
            qspi_command: last_bit = (bit_cnt == 5'd7);
            qspi_address: last_bit = (bit_cnt == 5'd23);
            qspi_dummy:   last_bit = (bit_cnt == {1'b0, dummy_clks} - 5'd1);
            default:      last_bit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= qspi_idle;
            cs_n       <= 1'b1;
            sclk       <= 1'b0;
            run_en     <= 1'b0;
            bit_cnt    <= '0;
            nib_cnt    <= '0;
            have_instr <= 1'b0;
        end else if (frame_start) begin
            state      <= qspi_idle;              // Abort and restart the read
            cs_n       <= 1'b1;
            sclk       <= 1'b0;
            run_en     <= cfg.enable;
            dummy_clks <= cfg.dummy_cycles;
            cmd_sr     <= {`QSPI_READ_CMD, cfg.start_addr};
            bit_cnt    <= '0;
            nib_cnt    <= '0;
            have_instr <= 1'b0;
        end else begin
            if (push) begin
                have_instr <= 1'b0;
            end
            case (state)
                qspi_idle: begin
                    if (run_en) begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'd1) begin    // CS high for two clocks
                            cs_n    <= 1'b0;
                            bit_cnt <= '0;
                            state   <= qspi_command;
                        end
                    end
                end
                qspi_command, qspi_address, qspi_dummy: begin
                    sclk <= ~sclk;
                    if (fall) begin
                        cmd_sr  <= {cmd_sr[30:0], 1'b0};
                        bit_cnt <= last_bit ? 5'd0 : bit_cnt + 5'd1;
                        if (last_bit && state == qspi_command) begin
                            state <= qspi_address;
                        end else if (last_bit && state == qspi_address) begin
                            state <= (dummy_clks == '0) ? qspi_data : qspi_dummy;
                        end else if (last_bit) begin
                            state <= qspi_data;
                        end
                    end
                end
                qspi_data: begin
                    sclk <= ~sclk;
                    if (fall && have_instr && full) begin
                        state <= qspi_stall;          // SCLK parks low
                    end else if (!fall) begin
                        nib_sr <= {nib_sr[4*`NIBBLES_PER_INSTR-5:0], io_in};
                        if (nib_cnt == 3'(`NIBBLES_PER_INSTR - 1)) begin
                            nib_cnt    <= '0;
                            have_instr <= 1'b1;
                        end else begin
                            nib_cnt <= nib_cnt + 3'd1;
                        end
                    end
                end
                qspi_stall: begin
                    if (!full) begin
                        state <= qspi_data;           // Word goes out this clock
                    end
                end
                default: state <= qspi_idle;
            endcase
        end
    end

endmodule

// File: instr_queue.sv
// Four-entry circular FIFO of draw instructions between the flash reader and the decoder
`timescale 1ns/1ps
`include "vga_stream_consts.svh"

module instr_queue (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   push,
    input  vga_stream_pkg::instr_t wr_instr,
    output logic                   full,
    input  logic                   pop,
    output vga_stream_pkg::instr_t head,
    output logic                   empty
);
    import vga_stream_pkg::*;

    localparam int ptr_w = $clog2(`QUEUE_DEPTH);

    instr_t           mem [`QUEUE_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    assign full  = (count == (ptr_w+1)'(`QUEUE_DEPTH));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;                             // Whole queue dropped at once
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push && !full) wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (ptr_w+1)'(push && !full) - (ptr_w+1)'(pop && !empty);
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) mem[wr_ptr] <= wr_instr;
    end

    // Reader and decoder must respect the flags
    flow_ok: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty) && !(push && full));

endmodule

// File: run_decoder.sv
// Run-length decoder that paints the head instruction's colour over its run of pixels
`timescale 1ns/1ps

module run_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_start,
    input  logic                    pixel_req,
    input  vga_stream_pkg::instr_t  head,
    input  logic                    empty,
    output logic                    pop,
    output vga_stream_pkg::colour_t rgb
);
    import vga_stream_pkg::*;

    run_t remaining;                              // Pixels left after the current one
    logic loaded;                                 // Remaining belongs to the head
    run_t count_now;
    logic paint;

    assign paint     = pixel_req && !empty;
    assign count_now = loaded ? remaining : head.run;
    assign pop       = paint && (count_now == '0); // Last pixel of this run

    always_ff @(posedge clk) begin
        if (reset) begin
            loaded <= 1'b0;
            rgb    <= '0;
        end else begin
            rgb <= paint ? head.colour : '0;      // Black on underrun and blanking
            if (frame_start) begin
                loaded <= 1'b0;                   // Drop any partial run
            end else if (paint) begin
                loaded <= !pop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (paint) begin
            remaining <= count_now - run_t'(1);
        end
    end

endmodule

// File: vga_timing.sv
// 640x480 VGA sync generator with pixel request and a frame start pulse for the stream
`timescale 1ns/1ps
`include "vga_stream_consts.svh"

module vga_timing (
    input  logic clk,
    input  logic reset,
    output logic pixel_req,
    output logic frame_start,
    output logic hsync,
    output logic vsync,
    output logic de
);
    localparam int h_sync_start = `H_ACTIVE + `H_FRONT;
    localparam int h_sync_end   = h_sync_start + `H_SYNC;
    localparam int v_sync_start = `V_ACTIVE + `V_FRONT;
    localparam int v_sync_end   = v_sync_start + `V_SYNC;

    logic [9:0] h_count;
    logic [9:0] v_count;
    logic       h_last;
    logic       v_last;
    logic       in_hsync;
    logic       in_vsync;

    assign h_last   = (h_count == 10'(`H_TOTAL - 1));
    assign v_last   = (v_count == 10'(`V_TOTAL - 1));
    assign in_hsync = (h_count >= 10'(h_sync_start)) && (h_count < 10'(h_sync_end));
    assign in_vsync = (v_count >= 10'(v_sync_start)) && (v_count < 10'(v_sync_end));

    assign pixel_req   = (h_count < 10'(`H_ACTIVE)) && (v_count < 10'(`V_ACTIVE));
    assign frame_start = (h_count == '0) && (v_count == 10'(`V_ACTIVE)); // First blank line

    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_count <= h_last ? '0 : h_count + 10'd1;
            if (h_last) begin
                v_count <= v_last ? '0 : v_count + 10'd1;
            end
        end
    end

    // One stage late to line up with the decoder colour register
    always_ff @(posedge clk) begin
        if (reset) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            hsync <= !in_hsync;                   // Active low
            vsync <= !in_vsync;
            de    <= pixel_req;
        end
    end

endmodule

// File: vga_stream_top.sv
// Top level of the flash-to-VGA stream engine, wiring registers, reader, queue, decoder, timing
`timescale 1ns/1ps

module vga_stream_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cfg_req,
    input  vga_stream_pkg::cfg_sel_t cfg_sel,
    input  logic [23:0]              cfg_wdata,
    output logic                     cfg_ack,
    output logic                     sclk,
    output logic                     cs_n,
    output logic [3:0]               io_out,
    output logic [3:0]               io_oe,
    input  logic [3:0]               io_in,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     de,
    output vga_stream_pkg::colour_t  rgb
);
    import vga_stream_pkg::*;

    stream_cfg_t cfg;
    instr_t      rd_instr;                        // Reader to queue
    instr_t      head;                            // Queue to decoder
    logic        push;
    logic        full;
    logic        pop;
    logic        empty;
    logic        pixel_req;
    logic        frame_start;

    display_regs u_display_regs (
        .clk(clk), .reset(reset), .cfg_req(cfg_req), .cfg_sel(cfg_sel),
        .cfg_wdata(cfg_wdata), .cfg_ack(cfg_ack), .cfg(cfg)
    );

    qspi_reader u_qspi_reader (
        .clk(clk), .reset(reset), .cfg(cfg), .frame_start(frame_start), .full(full),
        .push(push), .instr(rd_instr), .sclk(sclk), .cs_n(cs_n),
        .io_out(io_out), .io_oe(io_oe), .io_in(io_in)
    );

    instr_queue u_instr_queue (
        .clk(clk), .reset(reset), .flush(frame_start), .push(push), .wr_instr(rd_instr),
        .full(full), .pop(pop), .head(head), .empty(empty)
    );

    run_decoder u_run_decoder (
        .clk(clk), .reset(reset), .frame_start(frame_start), .pixel_req(pixel_req),
        .head(head), .empty(empty), .pop(pop), .rgb(rgb)
    );

    vga_timing u_vga_timing (
        .clk(clk), .reset(reset), .pixel_req(pixel_req), .frame_start(frame_start),
        .hsync(hsync), .vsync(vsync), .de(de)
    );

endmodule

// File: qspi_flash_model.sv
// Behavioural quad-SPI flash for the testbench, answers the 6B quad-output read from a byte array
`timescale 1ns/1ps

module qspi_flash_model (
    input  logic        sclk,
    input  logic        cs_n,
    input  logic [3:0]  io_out,
    input  logic [3:0]  dummy_clks,                    // Read latency set in the device
    output logic [3:0]  io_in,
    output logic [7:0]  rec_cmd,
    output logic [23:0] rec_addr,
    output int          rise_cnt                       // SCLK rising edges since CS fell
);
    logic [7:0] mem [4096];
    int         nib;
    logic [7:0] data_byte;

    initial begin
        io_in    = 4'h0;
        rec_cmd  = 8'h00;
        rec_addr = 24'h000000;
        rise_cnt = 0;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = i[7:0] ^ {i[11:8], i[11:8]};     // Background pattern over all address bits
        end
    end

    // SCLK idles low, so a CS fall arrives with sclk low
    always @(posedge sclk or negedge cs_n) begin
        if (!sclk) begin
            rise_cnt <= 0;
        end else if (!cs_n) begin
            if (rise_cnt < 8) begin
                rec_cmd <= {rec_cmd[6:0], io_out[0]};
            end else if (rise_cnt < 32) begin
                rec_addr <= {rec_addr[22:0], io_out[0]};
            end
            rise_cnt <= rise_cnt + 1;
        end
    end

    // Next nibble goes out on the falling edge, high nibble of each byte first
    always @(negedge sclk) begin
        if (!cs_n && rise_cnt >= 32 + int'(dummy_clks)) begin
            nib       = rise_cnt - 32 - int'(dummy_clks);
            data_byte = mem[(int'(rec_addr) + nib / 2) % 4096];
            io_in    <= nib[0] ? data_byte[3:0] : data_byte[7:4];
        end
    end

endmodule

// File: vga_stream_tb.sv
// Testbench for the flash-to-VGA stream engine, run with vga_stream_tb as top over sources.f
`timescale 1ns/1ps
`include "vga_stream_consts.svh"

module vga_stream_tb;
    import vga_stream_pkg::*;

    localparam int          n_instr    = 80;        // 80 runs of 16+ pixels fill two lines
    localparam int          pix_check  = 2 * `H_ACTIVE;
    localparam int          read_dummy = 6;
    localparam flash_addr_t img_a      = 24'h000100;
    localparam flash_addr_t img_b      = 24'h000600;
    localparam int          sig_de     = 0;
    localparam int          sig_hsync  = 1;
    localparam int          sig_vsync  = 2;
    localparam int          sig_cs_n   = 3;
    localparam int          sig_empty  = 4;

    logic        clk;
    logic        reset;
    logic        cfg_req;
    cfg_sel_t    cfg_sel;
    logic [23:0] cfg_wdata;
    logic        cfg_ack;
    logic        sclk;
    logic        cs_n;
    logic [3:0]  io_out;
    logic [3:0]  io_oe;
    logic [3:0]  io_in;
    logic        hsync;
    logic        vsync;
    logic        de;
    colour_t     rgb;

    instr_t      stim [n_instr];                    // Colour and run pairs
    colour_t     expected [2][pix_check];           // Pixel order for both images
    int unsigned rand_state;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    logic [7:0]  flash_cmd;
    flash_addr_t flash_addr;
    int          flash_rises;
    stream_cfg_t seen;
    instr_t      entry;
    int          pix_idx;
    int          low_len;
    int          period;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    vga_stream_top u_vga_stream_top (
        .clk(clk), .reset(reset), .cfg_req(cfg_req), .cfg_sel(cfg_sel),
        .cfg_wdata(cfg_wdata), .cfg_ack(cfg_ack), .sclk(sclk), .cs_n(cs_n),
        .io_out(io_out), .io_oe(io_oe), .io_in(io_in), .hsync(hsync), .vsync(vsync),
        .de(de), .rgb(rgb)
    );

    qspi_flash_model u_qspi_flash_model (
        .sclk(sclk), .cs_n(cs_n), .io_out(io_out), .dummy_clks(4'(read_dummy)),
        .io_in(io_in), .rec_cmd(flash_cmd), .rec_addr(flash_addr), .rise_cnt(flash_rises)
    );

    function automatic int unsigned next_rand(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic signal_value(input int sig);
        case (sig)
            sig_de:    return de;
            sig_hsync: return hsync;
            sig_vsync: return vsync;
            sig_cs_n:  return cs_n;
            default:   return u_vga_stream_top.empty;
        endcase
    endfunction

    task automatic note_error(input string msg);
        $display("FAIL @%0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic abort_run(input string msg);
        test_errors++;
        $display("%s", msg);
        $display("test failed");
        $finish;
    endtask

    task automatic close_test(input int num, input string name);
        if (test_errors == 0) begin
            $display("check %0d %s: ok", num, name);
            tests_ok++;
        end else begin
            $display("check %0d %s: %0d errors", num, name, test_errors);
            tests_bad++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic wait_level(input int sig, input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (signal_value(sig) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (signal_value(sig) !== level) abort_run({"timed out waiting for ", what});
    endtask

    task automatic time_pulse(input int sig, input int limit, input string what,
                              output int low_cycles, output int period_cycles);
        wait_level(sig, 1'b1, limit, what);
        wait_level(sig, 1'b0, limit, what);
        low_cycles = 0;
        while (signal_value(sig) === 1'b0 && low_cycles < limit) begin
            @(negedge clk);
            low_cycles++;
        end
        period_cycles = low_cycles;
        while (signal_value(sig) === 1'b1 && period_cycles < limit) begin
            @(negedge clk);
            period_cycles++;
        end
        if (signal_value(sig) !== 1'b0) abort_run({"no second falling edge on ", what});
    endtask

    task automatic host_write(input cfg_sel_t sel, input logic [23:0] data);
        int n;
        n = 0;
        if (cfg_ack !== 1'b0) note_error("ack high before the request");
        @(posedge clk);
        cfg_req   <= 1'b1;
        cfg_sel   <= sel;
        cfg_wdata <= data;
        @(negedge clk);
        if (cfg_ack !== 1'b0) note_error("ack rose in the same cycle as req");
        while (cfg_ack !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (cfg_ack !== 1'b1) abort_run("display registers never acknowledged the write");
        @(posedge clk);
        cfg_req <= 1'b0;
        @(negedge clk);
        if (cfg_ack !== 1'b1) note_error("ack fell before req low was seen");
        n = 0;
        while (cfg_ack !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (cfg_ack !== 1'b0) abort_run("ack stayed high after req was dropped");
    endtask

    task automatic store_nibble(input flash_addr_t base, input int m, input logic [3:0] val);
        int         a;
        logic [7:0] b;
        a = (int'(base) + m / 2) % 4096;
        b = u_qspi_flash_model.mem[a];
        b = (m % 2 == 0) ? {val, b[3:0]} : {b[7:4], val};
        u_qspi_flash_model.mem[a] = b;
    endtask

    task automatic store_image(input flash_addr_t base, input colour_t mask);
        logic [19:0] word;
        for (int k = 0; k < n_instr; k++) begin
            word = {2'b00, stim[k]} ^ {2'b00, mask, 10'd0};   // Two pad bits lead the word
            for (int j = 0; j < `NIBBLES_PER_INSTR; j++) begin
                store_nibble(base, `NIBBLES_PER_INSTR * k + j, word[19 - 4 * j -: 4]);
            end
        end
    endtask

    task automatic check_pixels(input int img, input int n_pix);
        int idx;
        int n;
        idx = 0;
        n = 0;
        wait_level(sig_de, 1'b1, 450000, "the first active pixel");
        while (idx < n_pix && n < 2 * n_pix) begin
            if (de === 1'b1) begin
                if (rgb !== expected[img][idx]) begin
                    note_error($sformatf("pixel %0d rgb %h, expected %h",
                                         idx, rgb, expected[img][idx]));
                end
                idx++;
            end else if (rgb !== 8'h00) begin
                note_error($sformatf("rgb %h while de is low", rgb));
            end
            @(negedge clk);
            n++;
        end
        if (idx < n_pix) abort_run("active pixels stopped before the checked lines ended");
    endtask

    initial begin
        reset     <= 1'b1;
        cfg_req   <= 1'b0;
        cfg_sel   <= sel_ctrl;
        cfg_wdata <= '0;
        rand_state = 32'd68589;
        for (int k = 0; k < n_instr; k++) begin
            rand_state = next_rand(rand_state);
            stim[k] = {rand_state[23:16], run_t'(15 + rand_state[15:8] % 65)}; // 16 to 80 pixels
        end
        pix_idx = 0;
        for (int k = 0; k < n_instr; k++) begin
            entry = stim[k];
            for (int p = 0; p <= int'(entry.run); p++) begin    // Run n paints n+1 pixels
                if (pix_idx < pix_check) begin
                    expected[0][pix_idx] = entry.colour;
                    expected[1][pix_idx] = ~entry.colour;
                end
                pix_idx++;
            end
        end

        // Test 1 covers reset values and a quiet flash bus
        repeat (7) @(posedge clk);
        @(negedge clk);
        if (cs_n !== 1'b1 || sclk !== 1'b0 || io_oe !== 4'b0000) begin
            note_error("flash pins not idle in reset");
        end
        if (cfg_ack !== 1'b0 || hsync !== 1'b1 || vsync !== 1'b1 || de !== 1'b0 ||
            rgb !== 8'h00) begin
            note_error("host or video outputs wrong in reset");
        end
        @(posedge clk);
        reset <= 1'b0;
        store_image(img_a, 8'h00);
        store_image(img_b, 8'hFF);                         // Second image has inverted colours
        repeat (40) begin
            @(negedge clk);
            if (cs_n !== 1'b1 || sclk !== 1'b0 || io_oe !== 4'b0000) begin
                note_error("flash activity before enable");
            end
            if (rgb !== 8'h00) note_error($sformatf("rgb %h with no image running", rgb));
        end
        close_test(1, "reset state");

        // Test 2 covers the host writes
        host_write(sel_addr, img_a);
        seen = u_vga_stream_top.cfg;
        if (seen.start_addr !== img_a) note_error($sformatf("start address %h", seen.start_addr));
        if (seen.enable !== 1'b0 || seen.dummy_cycles !== 4'd0) begin
            note_error("control changed by address write");
        end
        if (cs_n !== 1'b1) note_error("flash selected before enable");
        host_write(sel_ctrl, {16'h0000, 4'(read_dummy), 3'b000, 1'b1});
        seen = u_vga_stream_top.cfg;
        if (seen.enable !== 1'b1) note_error("enable not set");
        if (seen.dummy_cycles !== 4'(read_dummy)) note_error($sformatf("dummy %0d", seen.dummy_cycles));
        if (seen.start_addr !== img_a) note_error("start address changed by control write");
        close_test(2, "host handshake");

        // Test 3 covers the read header seen by the flash
        wait_level(sig_cs_n, 1'b0, 450000, "flash chip select");
        if (io_oe !== 4'b0001) note_error($sformatf("io_oe %b while sending the command", io_oe));
        wait_level(sig_empty, 1'b0, 2000, "the first instruction in the queue");
        if (io_oe !== 4'b0000) note_error($sformatf("io_oe %b while reading data", io_oe));
        if (flash_cmd !== `QSPI_READ_CMD) note_error($sformatf("command %h", flash_cmd));
        if (flash_addr !== img_a) note_error($sformatf("address %h", flash_addr));
        if (flash_rises - 32 - `NIBBLES_PER_INSTR != read_dummy) begin
            note_error($sformatf("%0d dummy clocks", flash_rises - 32 - `NIBBLES_PER_INSTR));
        end
        close_test(3, "flash read header");

        // Test 4 covers the first two lines of the first image
        check_pixels(0, pix_check);
        close_test(4, "pixels of first image");

        // Test 5 covers sync widths and periods
        time_pulse(sig_hsync, 2000, "hsync", low_len, period);
        if (low_len != `H_SYNC) note_error($sformatf("hsync low for %0d clocks", low_len));
        if (period != `H_TOTAL) note_error($sformatf("line period %0d clocks", period));
        time_pulse(sig_vsync, 450000, "vsync", low_len, period);
        if (low_len != `V_SYNC * `H_TOTAL) begin
            note_error($sformatf("vsync low for %0d clocks", low_len));
        end
        if (period != `V_TOTAL * `H_TOTAL) note_error($sformatf("frame period %0d clocks", period));
        close_test(5, "sync timing");

        // Test 6 moves the start address, picked up at the next frame start
        wait_level(sig_de, 1'b1, 450000, "the active area");
        host_write(sel_addr, img_b);
        wait_level(sig_vsync, 1'b0, 450000, "vsync after the address change");
        check_pixels(1, `H_ACTIVE);
        close_test(6, "second image");

        $display("summary: %0d checks ok, %0d with errors, %0d errors in all",
                 tests_ok, tests_bad, total_errors);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
vga_stream_pkg.sv
display_regs.sv
qspi_reader.sv
instr_queue.sv
run_decoder.sv
vga_timing.sv
vga_stream_top.sv
qspi_flash_model.sv
vga_stream_tb.sv

// File: Bender.yml
package:
  name: vga_stream

sources:
  - include_dirs:
      - .
    files:
      - vga_stream_pkg.sv
      - display_regs.sv
      - qspi_reader.sv
      - instr_queue.sv
      - run_decoder.sv
      - vga_timing.sv
      - vga_stream_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - qspi_flash_model.sv
      - vga_stream_tb.sv
